// ==== verilog/cpu_addr_pkg.sv ====
package cpu_addr_pkg;

    localparam int INST_W = 32;

    typedef logic [31:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // boot rom entry and general exception entry
    localparam addr_t RESET_VECTOR = 32'hbfc00000;
    localparam addr_t EXC_VECTOR   = 32'hbfc00380;

    // cp0 cause codes
    localparam logic [4:0] EXCODE_ADEL = 5'h04;

endpackage

// ==== verilog/fetch_bus_pkg.sv ====
package fetch_bus_pkg;

    // one fetched instruction handed to decode
    typedef struct packed {
        logic                 bd;
        logic                 ex;
        logic [4:0]           excode;
        cpu_addr_pkg::inst_t  inst;
        cpu_addr_pkg::addr_t  pc;
    } fetch_bundle_t;

endpackage

// ==== verilog/fetch_mem_if.sv ====
`timescale 1ns/10ps

interface fetch_mem_if;

    logic                req;
    cpu_addr_pkg::addr_t addr;
    logic                addr_ok;
    logic                data_ok;
    cpu_addr_pkg::inst_t rdata;

    // request side, owns req
    modport ctrl (output req, input addr_ok, input data_ok);

    // address generator, addr must hold until accepted
    modport agen (output addr, input req, input addr_ok);

    // return side, pairs addresses with words
    modport data (input addr, input data_ok, input rdata);

endinterface

// ==== verilog/redirect_if.sv ====
`timescale 1ns/10ps

interface redirect_if;

    // from decode
    logic                br_op;
    logic                br_stall;
    logic                br_taken;
    cpu_addr_pkg::addr_t br_target;

    // from writeback
    logic                ex;
    logic                eret;
    cpu_addr_pkg::addr_t epc;

    modport consumer (
        input br_op, input br_stall, input br_taken, input br_target,
        input ex, input eret, input epc
    );

endinterface

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl #(
    parameter int FETCH_DEPTH = 2,
    localparam int CW = $clog2(FETCH_DEPTH + 1)
) (
    input  logic          clk,
    input  logic          reset,
    fetch_mem_if.ctrl     mem,
    redirect_if.consumer  redir,
    output logic          accept,
    output logic          flush,
    output logic [CW-1:0] drop_count,
    output logic          slot_done,
    input  logic [CW-1:0] buf_count,
    input  logic          pop
);

    typedef enum logic [1:0] {
        ST_RUN,
        ST_BR_PEND,
        ST_DS_ISSUED,
        ST_FLUSH
    } state_t;

    state_t        state;
    state_t        state_next;
    logic          req_r;
    logic          req_next;
    logic          pending;
    logic          redirect_ex;
    logic          allow;
    logic [CW-1:0] outstanding;
    logic [CW:0]   occ_now;
    logic [CW:0]   items;

    assign mem.req     = req_r;
    assign accept      = req_r & mem.addr_ok;
    assign pending     = req_r & ~mem.addr_ok;
    assign redirect_ex = redir.ex | redir.eret;
    assign flush       = (state == ST_FLUSH);

    // requests on the bus plus words waiting in the buffer
    assign occ_now = {1'b0, outstanding} + {1'b0, buf_count};
    // items left once this cycle settles, oldest of them is the delay slot
    assign items   = occ_now + accept - pop;

    always_comb begin
        state_next = state;
        slot_done  = 1'b0;
        drop_count = '0;
        case (state)
            ST_RUN: begin
                if (redir.br_op && redir.br_taken) begin
                    if (items == 0) begin
                        state_next = ST_BR_PEND;
                    end else if (pending) begin
                        // request on the bus is past the slot, kill it on accept
                        state_next = ST_DS_ISSUED;
                        drop_count = CW'(items - 1'b1);
                    end else begin
                        slot_done  = 1'b1;
                        drop_count = CW'(items - 1'b1);
                    end
                end
            end
            ST_BR_PEND: begin
                // this accept is the delay slot itself
                if (accept) begin
                    slot_done  = 1'b1;
                    state_next = ST_RUN;
                end
            end
            ST_DS_ISSUED: begin
                if (accept) begin
                    slot_done  = 1'b1;
                    drop_count = CW'(1);
                    state_next = ST_RUN;
                end
            end
            default: begin
                // wait until every owed data_ok is swallowed
                if (!req_r && (outstanding - CW'(mem.data_ok)) == '0) begin
                    state_next = ST_RUN;
                end
            end
        endcase
        if (redirect_ex) begin
            state_next = ST_FLUSH;
            slot_done  = 1'b0;
            drop_count = '0;
        end
    end

    assign allow    = ~redir.br_stall & ~redirect_ex & (state != ST_FLUSH);
    assign req_next = pending | (allow && (occ_now + accept) < FETCH_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_RUN;
            req_r       <= 1'b0;
            outstanding <= '0;
        end else begin
            state       <= state_next;
            req_r       <= req_next;
            outstanding <= outstanding + CW'(accept) - CW'(mem.data_ok);
        end
    end

endmodule

// ==== verilog/pc_gen.sv ====
`timescale 1ns/10ps

module pc_gen (
    input  logic          clk,
    input  logic          reset,
    fetch_mem_if.agen     mem,
    redirect_if.consumer  redir,
    input  logic          accept,
    input  logic          slot_done,
    input  logic          flush
);

    cpu_addr_pkg::addr_t pc;
    cpu_addr_pkg::addr_t ex_pc;
    cpu_addr_pkg::addr_t br_tgt_r;
    cpu_addr_pkg::addr_t br_tgt;
    logic                free;

    assign mem.addr = pc;

    // addr may only move while no request waits on the bus
    assign free = ~mem.req | accept;

    // target arrives with the pulse when the slot is already fetched
    assign br_tgt = redir.br_op ? redir.br_target : br_tgt_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpu_addr_pkg::RESET_VECTOR;
        end else if (flush && free) begin
            pc <= ex_pc;
        end else if (slot_done) begin
            pc <= br_tgt;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    // pending redirect targets
    always_ff @(posedge clk) begin
        if (redir.ex) begin
            ex_pc <= cpu_addr_pkg::EXC_VECTOR;
        end else if (redir.eret) begin
            ex_pc <= redir.epc;
        end
        if (redir.br_op && redir.br_taken) begin
            br_tgt_r <= redir.br_target;
        end
    end

endmodule

// ==== verilog/inst_buffer.sv ====
`timescale 1ns/10ps

module inst_buffer #(
    parameter int FETCH_DEPTH = 2,
    localparam int CW = $clog2(FETCH_DEPTH + 1),
    localparam int PW = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1
) (
    input  logic                         clk,
    input  logic                         reset,
    fetch_mem_if.data                    mem,
    input  logic                         accept,
    input  logic                         flush,
    input  logic [CW-1:0]                drop_count,
    redirect_if.consumer                 redir,
    output fetch_bus_pkg::fetch_bundle_t bundle,
    output logic                         valid,
    input  logic                         ds_allowin,
    output logic                         pop,
    output logic [CW-1:0]                buf_count
);

    cpu_addr_pkg::addr_t   pc_q   [FETCH_DEPTH];
    cpu_addr_pkg::inst_t   inst_q [FETCH_DEPTH];
    logic [FETCH_DEPTH-1:0] filled;
    logic [FETCH_DEPTH-1:0] dead;
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          fill_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [PW-1:0]          wr_after;
    logic                   head_fill_now;
    logic                   head_ready;
    logic                   retire;
    logic                   bd_pend;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(FETCH_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // bypass when the word lands on an empty head
    assign head_fill_now = mem.data_ok & (fill_ptr == rd_ptr);
    assign head_ready    = filled[rd_ptr] | head_fill_now;
    assign valid         = head_ready & ~dead[rd_ptr] & ~flush;
    assign pop           = valid & ds_allowin;
    // killed entries leave on their own
    assign retire        = head_ready & (dead[rd_ptr] | ds_allowin) & ~flush;
    assign wr_after      = accept ? next_ptr(wr_ptr) : wr_ptr;

    assign bundle.bd     = bd_pend;
    assign bundle.pc     = pc_q[rd_ptr];
    assign bundle.inst   = filled[rd_ptr] ? inst_q[rd_ptr] : mem.rdata;
    assign bundle.ex     = |pc_q[rd_ptr][1:0];
    assign bundle.excode = bundle.ex ? cpu_addr_pkg::EXCODE_ADEL : 5'd0;

    always_ff @(posedge clk) begin : ctrl_seq
        int idx;
        if (reset || flush) begin
            wr_ptr    <= '0;
            fill_ptr  <= '0;
            rd_ptr    <= '0;
            filled    <= '0;
            dead      <= '0;
            buf_count <= '0;
            bd_pend   <= 1'b0;
        end else begin
            if (accept) begin
                dead[wr_ptr] <= 1'b0;
                wr_ptr       <= next_ptr(wr_ptr);
            end
            if (mem.data_ok) begin
                filled[fill_ptr] <= 1'b1;
                fill_ptr         <= next_ptr(fill_ptr);
            end
            if (retire) begin
                filled[rd_ptr] <= 1'b0;
                rd_ptr         <= next_ptr(rd_ptr);
            end
            // kill the youngest entries, counted back from the write pointer
            for (int k = 0; k < FETCH_DEPTH; k++) begin
                idx = (int'(wr_after) + FETCH_DEPTH - 1 - k) % FETCH_DEPTH;
                if (k < int'(drop_count)) begin
                    dead[idx] <= 1'b1;
                end
            end
            buf_count <= buf_count + CW'(mem.data_ok) - CW'(retire);
            if (redir.br_op) begin
                bd_pend <= 1'b1;
            end else if (pop) begin
                bd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q[wr_ptr] <= mem.addr;
        end
        if (mem.data_ok) begin
            inst_q[fill_ptr] <= mem.rdata;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage #(
    parameter int FETCH_DEPTH = 2,
    localparam int CW = $clog2(FETCH_DEPTH + 1)
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_allowin,
    input  logic                         br_op,
    input  logic                         br_stall,
    input  logic                         br_taken,
    input  cpu_addr_pkg::addr_t          br_target,
    input  logic                         ws_ex,
    input  logic                         ws_eret,
    input  cpu_addr_pkg::addr_t          cp0_epc,
    output logic                         inst_req,
    output cpu_addr_pkg::addr_t          inst_addr,
    input  logic                         inst_addr_ok,
    input  logic                         inst_data_ok,
    input  cpu_addr_pkg::inst_t          inst_rdata,
    output logic                         fs_valid,
    output fetch_bus_pkg::fetch_bundle_t fs_bundle
);

    fetch_mem_if mem_bus ();
    redirect_if  redir ();

    logic          accept;
    logic          flush;
    logic          slot_done;
    logic          pop;
    logic [CW-1:0] drop_count;
    logic [CW-1:0] buf_count;

    assign inst_req         = mem_bus.req;
    assign inst_addr        = mem_bus.addr;
    assign mem_bus.addr_ok  = inst_addr_ok;
    assign mem_bus.data_ok  = inst_data_ok;
    assign mem_bus.rdata    = inst_rdata;

    assign redir.br_op      = br_op;
    assign redir.br_stall   = br_stall;
    assign redir.br_taken   = br_taken;
    assign redir.br_target  = br_target;
    assign redir.ex         = ws_ex;
    assign redir.eret       = ws_eret;
    assign redir.epc        = cp0_epc;

    fetch_ctrl #(.FETCH_DEPTH(FETCH_DEPTH)) u_fetch_ctrl (
        .clk(clk), .reset(reset), .mem(mem_bus.ctrl), .redir(redir.consumer),
        .accept(accept), .flush(flush), .drop_count(drop_count),
        .slot_done(slot_done), .buf_count(buf_count), .pop(pop)
    );

    pc_gen u_pc_gen (
        .clk(clk), .reset(reset), .mem(mem_bus.agen), .redir(redir.consumer),
        .accept(accept), .slot_done(slot_done), .flush(flush)
    );

    inst_buffer #(.FETCH_DEPTH(FETCH_DEPTH)) u_inst_buffer (
        .clk(clk), .reset(reset), .mem(mem_bus.data), .accept(accept),
        .flush(flush), .drop_count(drop_count), .redir(redir.consumer),
        .bundle(fs_bundle), .valid(fs_valid), .ds_allowin(ds_allowin),
        .pop(pop), .buf_count(buf_count)
    );

endmodule

// ==== tb/inst_mem_model.sv ====
`timescale 1ns/10ps

module inst_mem_model #(
    parameter logic [31:0] SEED     = 32'h1,
    parameter logic [31:0] SCRAMBLE = 32'h0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  cpu_addr_pkg::addr_t addr,
    output logic                addr_ok,
    output logic                data_ok,
    output cpu_addr_pkg::inst_t rdata
);

    integer              seed;
    int                  now;
    cpu_addr_pkg::addr_t pend_addr [$];
    int                  pend_due  [$];

    initial begin
        seed    = SEED;
        now     = 0;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            now++;
            if (reset) begin
                addr_ok = 1'b0;
                data_ok = 1'b0;
                pend_addr.delete();
                pend_due.delete();
            end else begin
                // in order, at most one word per cycle
                data_ok = 1'b0;
                if (pend_due.size() > 0 && pend_due[0] <= now) begin
                    data_ok = 1'b1;
                    rdata   = pend_addr.pop_front() ^ SCRAMBLE;
                    pend_due.delete(0);
                end
                // req and addr are registers, steady until the next edge
                addr_ok = (($random(seed) & 3) != 0);
                if (req && addr_ok) begin
                    pend_addr.push_back(addr);
                    pend_due.push_back(now + 1 + ($unsigned($random(seed)) % 3));
                end
            end
        end
    end

endmodule

// ==== tb/fetch_stage_tb.sv ====
`timescale 1ns/10ps

module fetch_stage_tb;

    localparam logic [31:0] SEED       = 32'h2391_8b81;
    localparam logic [31:0] SCRAMBLE   = 32'h5ee3_a17c;
    localparam logic [31:0] BOOT_PC    = 32'hbfc0_0000;
    localparam logic [31:0] EXC_PC     = 32'hbfc0_0380;
    localparam logic [4:0]  ADEL_CODE  = 5'd4;
    localparam int          N_BUNDLES  = 600;
    localparam int          MAX_CYCLES = 40 * N_BUNDLES;

    logic        clk;
    logic        reset;
    logic        ds_allowin;
    logic        br_op;
    logic        br_stall;
    logic        br_taken;
    logic [31:0] br_target;
    logic        ws_ex;
    logic        ws_eret;
    logic [31:0] cp0_epc;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    logic        fs_valid;
    fetch_bus_pkg::fetch_bundle_t fs_bundle;

    integer      seed;
    // expected stream
    logic [31:0] exp_pc;
    logic        exp_bd;
    logic        tgt_pend;
    logic [31:0] tgt_pc;
    int          br_quiet;
    int          ex_quiet;
    int          stall_left;
    int          delivered;
    int          cycles;
    int          redirects;
    // previous cycle values for the hold, stall and bus checks
    logic        prev_valid;
    logic        prev_allowin;
    logic        prev_pulse;
    logic        prev_req;
    logic        prev_addr_ok;
    logic [31:0] prev_addr;
    logic        prev_stall;
    fetch_bus_pkg::fetch_bundle_t prev_bundle;

    fetch_stage #(.FETCH_DEPTH(2)) u_fetch_stage (.*);

    inst_mem_model #(.SEED(SEED), .SCRAMBLE(SCRAMBLE)) u_inst_mem (
        .clk(clk), .reset(reset), .req(inst_req), .addr(inst_addr),
        .addr_ok(inst_addr_ok), .data_ok(inst_data_ok), .rdata(inst_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [70:0] expected,
                         input logic [70:0] actual);
        if (actual !== expected) begin
            fail_stop($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // now and then a misaligned target
    function automatic logic [31:0] random_target();
        logic [31:0] a;
        a = 32'hbfc1_0000 | (32'($random(seed)) & 32'h0000_fffc);
        if (rand_below(8) == 0) begin
            a[1:0] = 2'(rand_below(3) + 1);
        end
        return a;
    endfunction

    task automatic drive_inputs();
        int r;
        ds_allowin = (rand_below(4) != 0);
        br_op      = 1'b0;
        br_taken   = 1'b0;
        ws_ex      = 1'b0;
        ws_eret    = 1'b0;
        if (stall_left > 0) begin
            br_stall = 1'b1;
            stall_left--;
        end else if (rand_below(40) == 0) begin
            br_stall   = 1'b1;
            stall_left = rand_below(6);
        end else begin
            br_stall = 1'b0;
        end
        if (rand_below(16) == 0) begin
            cp0_epc = random_target();
        end
        r = rand_below(64);
        if (ex_quiet == 0 && r == 0) begin
            ws_ex = 1'b1;
        end else if (ex_quiet == 0 && r == 1) begin
            ws_eret = 1'b1;
        end else if (ex_quiet == 0 && r == 2) begin
            ws_ex   = 1'b1;
            ws_eret = 1'b1;
        end else if (ex_quiet == 0 && br_quiet == 0 && r >= 52) begin
            br_op     = 1'b1;
            br_taken  = rand_below(2);
            br_target = random_target();
        end
    endtask

    // sampled mid-cycle where the next rising edge sees the same values
    task automatic track_outputs();
        fetch_bus_pkg::fetch_bundle_t b;
        logic mis;
        b   = fs_bundle;
        mis = |exp_pc[1:0];
        if (prev_valid && !prev_allowin && !prev_pulse) begin
            check("hold fs_valid", 1'b1, fs_valid);
            check("hold fs_bundle", prev_bundle, b);
        end
        if (prev_stall && !prev_req) begin
            check("stall inst_req", 1'b0, inst_req);
        end
        // a waiting request keeps req and addr until addr_ok
        if (prev_req && !prev_addr_ok) begin
            check("bus inst_req held", 1'b1, inst_req);
            check("bus inst_addr held", prev_addr, inst_addr);
        end
        if (fs_valid && ds_allowin) begin
            check("bundle pc", exp_pc, b.pc);
            check("bundle inst", exp_pc ^ SCRAMBLE, b.inst);
            check("bundle bd", exp_bd, b.bd);
            check("bundle ex", mis, b.ex);
            check("bundle excode", mis ? ADEL_CODE : 5'd0, b.excode);
            if (exp_bd && tgt_pend) begin
                exp_pc   = tgt_pc;
                tgt_pend = 1'b0;
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
            exp_bd = 1'b0;
            delivered++;
            if (br_quiet > 0) begin
                br_quiet--;
            end
            if (ex_quiet > 0) begin
                ex_quiet--;
            end
        end
        // a pop in the pulse cycle still belongs to the old stream
        if (ws_ex || ws_eret) begin
            exp_pc   = ws_ex ? EXC_PC : cp0_epc;
            exp_bd   = 1'b0;
            tgt_pend = 1'b0;
            ex_quiet = 1;
            br_quiet = 0;
            redirects++;
        end else if (br_op) begin
            exp_bd   = 1'b1;
            tgt_pend = br_taken;
            tgt_pc   = br_target;
            br_quiet = 2;
            redirects++;
        end
        prev_valid   = fs_valid;
        prev_allowin = ds_allowin;
        prev_pulse   = br_op | ws_ex | ws_eret;
        prev_req     = inst_req;
        prev_addr_ok = inst_addr_ok;
        prev_addr    = inst_addr;
        prev_stall   = br_stall;
        prev_bundle  = b;
    endtask

    initial begin
        seed         = SEED;
        reset        = 1'b1;
        ds_allowin   = 1'b0;
        br_op        = 1'b0;
        br_stall     = 1'b0;
        br_taken     = 1'b0;
        br_target    = '0;
        ws_ex        = 1'b0;
        ws_eret      = 1'b0;
        cp0_epc      = BOOT_PC;
        exp_pc       = BOOT_PC;
        exp_bd       = 1'b0;
        tgt_pend     = 1'b0;
        tgt_pc       = '0;
        br_quiet     = 0;
        ex_quiet     = 0;
        stall_left   = 0;
        delivered    = 0;
        cycles       = 0;
        redirects    = 0;
        prev_valid   = 1'b0;
        prev_allowin = 1'b0;
        prev_pulse   = 1'b0;
        prev_req     = 1'b0;
        prev_addr_ok = 1'b0;
        prev_addr    = '0;
        prev_stall   = 1'b0;
        prev_bundle  = '0;
        repeat (3) begin
            @(posedge clk);
            #1;
            check("reset inst_req", 1'b0, inst_req);
            check("reset fs_valid", 1'b0, fs_valid);
        end
        @(negedge clk);
        reset = 1'b0;
        while (delivered < N_BUNDLES) begin
            drive_inputs();
            #1;
            track_outputs();
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                fail_stop($sformatf("timeout: only %0d of %0d bundles after %0d cycles",
                                    delivered, N_BUNDLES, cycles));
            end
            @(negedge clk);
        end
        $display("%0d bundles, %0d redirects, %0d cycles", delivered, redirects, cycles);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/cpu_addr_pkg.sv
verilog/fetch_bus_pkg.sv
verilog/fetch_mem_if.sv
verilog/redirect_if.sv
verilog/fetch_ctrl.sv
verilog/pc_gen.sv
verilog/inst_buffer.sv
verilog/fetch_stage.sv
tb/inst_mem_model.sv
tb/fetch_stage_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - verilog/cpu_addr_pkg.sv
  - verilog/fetch_bus_pkg.sv
  - verilog/fetch_mem_if.sv
  - verilog/redirect_if.sv
  - verilog/fetch_ctrl.sv
  - verilog/pc_gen.sv
  - verilog/inst_buffer.sv
  - verilog/fetch_stage.sv
  - target: test
    files:
      - tb/inst_mem_model.sv
      - tb/fetch_stage_tb.sv
